/* ex_stage.f */
logic/ex_pkg.sv
logic/ex_operand_mux.sv
logic/exec_alu.sv
logic/barrel_shifter.sv
logic/ex_result_reg.sv
logic/ex_stage.sv
tb/tb_clock_gen.sv
tb/ex_stage_props.sv
tb/ex_stage_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := ex_stage_tb
FILELIST  := ex_stage.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb/ex_stage_tb.sv */
module ex_stage_tb
    import ex_pkg::*;
#(
    parameter int DATA_WIDTH   = 32,
    parameter int NUM_CYCLES   = 400,
    parameter int RESET_CYCLES = 5
) ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SHAMT_W        = $clog2(DATA_WIDTH);
    // Stimulus twice over, reset and some slack
    localparam int TIMEOUT_CYCLES = 2 * NUM_CYCLES + RESET_CYCLES + 20;

    // One decoded instruction as the decoder would hand it over
    typedef struct packed {
        logic [DATA_WIDTH-1:0] op_a;
        logic [DATA_WIDTH-1:0] op_b;
        logic [DATA_WIDTH-1:0] imm_ext;
        logic [DATA_WIDTH-1:0] pc_4;
        logic [SHAMT_W-1:0]    shamt;
        alu_op_e               alu_op;
        shift_op_e             shift_op;
        logic                  b_sel;
        logic                  shamt_sel;
        exres_sel_e            exres_sel;
        logic                  movz;
        logic                  movn;
        logic                  reg_w;
        logic                  of_w_disen;
        logic [REG_ADDR_W-1:0] rd_addr;
    } item_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  reg_w;
        logic                  lf;
        logic                  zf;
        logic                  of;
    } result_t;

    logic                  clk;
    logic                  arst_n;
    logic                  issue;
    logic [DATA_WIDTH-1:0] op_a;
    logic [DATA_WIDTH-1:0] op_b;
    logic [DATA_WIDTH-1:0] imm_ext;
    logic [DATA_WIDTH-1:0] pc_4;
    logic [SHAMT_W-1:0]    shamt;
    alu_op_e               alu_op;
    shift_op_e             shift_op;
    logic                  b_sel;
    logic                  shamt_sel;
    exres_sel_e            exres_sel;
    logic                  movz;
    logic                  movn;
    logic                  reg_w;
    logic                  of_w_disen;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  res_valid;
    logic [DATA_WIDTH-1:0] res_data;
    logic [REG_ADDR_W-1:0] res_rd_addr;
    logic                  res_reg_w;
    logic                  res_lf;
    logic                  res_zf;
    logic                  res_of;

    int      seed      = 32'h22cd_26b0;
    int      cycle_cnt = 0;
    result_t exp_q[$];

    tb_clock_gen #(.PERIOD_NS(40)) u_clk (.clk(clk));

    ex_stage #(.DATA_WIDTH(DATA_WIDTH)) u_dut (.*);

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compares
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "ex_stage_tb stopped on error");
    endtask

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_addr(input string name, input logic [REG_ADDR_W-1:0] exp,
                              input logic [REG_ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0d ns %s expected %b actual %b", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic result_t model_result(input item_t it);
        result_t               e;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] alu;
        logic [DATA_WIDTH-1:0] sh;
        logic [SHAMT_W-1:0]    amt;
        longint                wide;
        longint                lim;
        // Moves see 0 | rt
        a    = (it.movz || it.movn) ? '0 : it.op_a;
        b    = it.b_sel ? it.imm_ext : it.op_b;
        amt  = it.shamt_sel ? it.op_a[SHAMT_W-1:0] : it.shamt;
        lim  = longint'(1) << (DATA_WIDTH - 1);
        wide = 0;
        alu  = '0;
        case (it.alu_op)
            ALU_ADD, ALU_ADDU: begin
                alu  = a + b;
                wide = longint'($signed(a)) + longint'($signed(b));
            end
            ALU_SUB, ALU_SUBU: begin
                alu  = a - b;
                wide = longint'($signed(a)) - longint'($signed(b));
            end
            ALU_AND:  alu = a & b;
            ALU_OR:   alu = a | b;
            ALU_XOR:  alu = a ^ b;
            ALU_NOR:  alu = ~(a | b);
            ALU_SLT:  alu[0] = $signed(a) < $signed(b);
            ALU_SLTU: alu[0] = a < b;
            ALU_LUI:  alu = b << (DATA_WIDTH / 2);
            default:  alu = '0;
        endcase
        // Exact result out of signed range
        e.of = (it.alu_op == ALU_ADD || it.alu_op == ALU_SUB) && (wide >= lim || wide < -lim);
        e.lf = (it.alu_op == ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));
        e.zf = (alu == '0);
        case (it.shift_op)
            SH_SLL:  sh = it.op_b << amt;
            SH_SRL:  sh = it.op_b >> amt;
            SH_SRA:  sh = $signed(it.op_b) >>> amt;
            default: sh = '0;
        endcase
        case (it.exres_sel)
            RES_ALU:    e.data = alu;
            RES_SHIFT:  e.data = sh;
            RES_LINK:   e.data = it.pc_4 + it.imm_ext * 4;
            default:    e.data = it.op_a;
        endcase
        e.rd_addr = it.rd_addr;
        e.reg_w   = it.reg_w && !(it.of_w_disen && e.of)
                    && !(it.movz && !e.zf) && !(it.movn && e.zf);
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic random_item(output item_t it);
        logic [31:0] r;
        it.op_a       = $random(seed);
        it.op_b       = $random(seed);
        it.imm_ext    = $random(seed);
        it.pc_4       = $random(seed);
        r             = $random(seed);
        it.shamt      = r[SHAMT_W-1:0];
        it.alu_op     = alu_op_e'(r[8:5] % 4'd11);
        it.shift_op   = shift_op_e'(r[10:9] % 2'd3);
        it.b_sel      = r[11];
        it.shamt_sel  = r[12];
        it.reg_w      = r[13] | r[14];
        it.of_w_disen = r[15];
        it.rd_addr    = r[20:16];
        it.movz       = 1'b0;
        it.movn       = 1'b0;
        it.exres_sel  = RES_ALU;
        // Instruction class
        case (r[23:21])
            3'd3: it.exres_sel = RES_SHIFT;
            3'd4: it.exres_sel = RES_LINK;
            3'd5: begin
                it.movz      = r[24];
                it.movn      = !r[24];
                it.alu_op    = ALU_OR;
                it.b_sel     = 1'b0;
                it.exres_sel = RES_PASS_A;
                // Half the moves see a zero rt
                if (r[25]) it.op_b = '0;
            end
            // Trapping add and sub, mostly register operands
            3'd6, 3'd7: begin
                it.alu_op = r[24] ? ALU_SUB : ALU_ADD;
                it.b_sel  = r[25] & r[26];
            end
            default: ;
        endcase
    endtask

    task automatic drive_item(input item_t it, input logic valid);
        issue      <= valid;
        op_a       <= it.op_a;
        op_b       <= it.op_b;
        imm_ext    <= it.imm_ext;
        pc_4       <= it.pc_4;
        shamt      <= it.shamt;
        alu_op     <= it.alu_op;
        shift_op   <= it.shift_op;
        b_sel      <= it.b_sel;
        shamt_sel  <= it.shamt_sel;
        exres_sel  <= it.exres_sel;
        movz       <= it.movz;
        movn       <= it.movn;
        reg_w      <= it.reg_w;
        of_w_disen <= it.of_w_disen;
        rd_addr    <= it.rd_addr;
    endtask

    initial begin
        item_t       it;
        logic [31:0] r;
        arst_n     = 1'b0;
        issue      = 1'b0;
        op_a       = '0;
        op_b       = '0;
        imm_ext    = '0;
        pc_4       = '0;
        shamt      = '0;
        alu_op     = ALU_ADD;
        shift_op   = SH_SLL;
        b_sel      = 1'b0;
        shamt_sel  = 1'b0;
        exres_sel  = RES_ALU;
        movz       = 1'b0;
        movn       = 1'b0;
        reg_w      = 1'b0;
        of_w_disen = 1'b0;
        rd_addr    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        // Reset values before the first issue
        @(negedge clk);
        check_bit("res_valid", 1'b0, res_valid);
        check_bit("res_reg_w", 1'b0, res_reg_w);
        check_data("res_data", '0, res_data);
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            random_item(it);
            r = $random(seed);
            // Issue about three cycles in four
            if (r[1:0] != 2'b00) begin
                exp_q.push_back(model_result(it));
                drive_item(it, 1'b1);
            end else begin
                drive_item(it, 1'b0);
            end
        end
        @(posedge clk);
        issue <= 1'b0;
        // Drain, watchdog covers a lost result
        while (exp_q.size() != 0) @(posedge clk);
        // One more edge so the last compare has run
        @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Result checking and watchdog
    //////////////////////////////////////////////////////////////////////

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        result_t e;
        if (arst_n && res_valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected result: res_valid high with nothing issued");
                stop_with_failure();
            end else begin
                e = exp_q.pop_front();
                check_data("res_data", e.data, res_data);
                check_addr("res_rd_addr", e.rd_addr, res_rd_addr);
                check_bit("res_reg_w", e.reg_w, res_reg_w);
                check_bit("res_lf", e.lf, res_lf);
                check_bit("res_zf", e.zf, res_zf);
                check_bit("res_of", e.of, res_of);
            end
        end else if (arst_n) begin
            check_bit("res_reg_w", 1'b0, res_reg_w);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, results still pending", cycle_cnt);
            stop_with_failure();
        end
    end

endmodule

/* tb/ex_stage_props.sv */
module ex_stage_props #(
    parameter int DATA_WIDTH = 32
) (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  issue,
    input logic                  res_valid,
    input logic                  res_reg_w,
    input logic [DATA_WIDTH-1:0] res_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // One result per issue, exactly one cycle later
    valid_follows_issue: assert property (
        @(posedge clk) disable iff (!arst_n) res_valid == $past(issue)
    ) else $error("res_valid does not follow issue by one cycle");

    // No register write without a result
    reg_w_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n) res_reg_w |-> res_valid
    ) else $error("res_reg_w high without res_valid");

    // Result fully known while valid
    data_known: assert property (
        @(posedge clk) disable iff (!arst_n) res_valid |-> !$isunknown(res_data)
    ) else $error("res_data has unknown bits while res_valid is high");

endmodule

bind ex_stage ex_stage_props #(.DATA_WIDTH(DATA_WIDTH)) u_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .issue     (issue),
    .res_valid (res_valid),
    .res_reg_w (res_reg_w),
    .res_data  (res_data)
);

/* tb/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free running, starts low
    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

/* logic/ex_stage.sv */
module ex_stage
    import ex_pkg::*;
#(
    parameter  int DATA_WIDTH = 32,
    localparam int SHAMT_W    = $clog2(DATA_WIDTH)
) (
    input  logic                  clk,
    input  logic                  arst_n,
    // Issued instruction
    input  logic                  issue,
    input  logic [DATA_WIDTH-1:0] op_a,
    input  logic [DATA_WIDTH-1:0] op_b,
    input  logic [DATA_WIDTH-1:0] imm_ext,
    input  logic [DATA_WIDTH-1:0] pc_4,
    input  logic [SHAMT_W-1:0]    shamt,
    input  alu_op_e               alu_op,
    input  shift_op_e             shift_op,
    input  logic                  b_sel,
    input  logic                  shamt_sel,
    input  exres_sel_e            exres_sel,
    input  logic                  movz,
    input  logic                  movn,
    input  logic                  reg_w,
    input  logic                  of_w_disen,
    input  logic [REG_ADDR_W-1:0] rd_addr,
    // Registered result
    output logic                  res_valid,
    output logic [DATA_WIDTH-1:0] res_data,
    output logic [REG_ADDR_W-1:0] res_rd_addr,
    output logic                  res_reg_w,
    output logic                  res_lf,
    output logic                  res_zf,
    output logic                  res_of
);

    //////////////////////////////////////////////////////////////////////
    // Internal datapath
    //////////////////////////////////////////////////////////////////////

    logic [DATA_WIDTH-1:0] alu_a;
    logic [DATA_WIDTH-1:0] alu_b;
    logic [SHAMT_W-1:0]    shift_amt;
    logic [DATA_WIDTH-1:0] link_target;
    logic [DATA_WIDTH-1:0] alu_res;
    logic [DATA_WIDTH-1:0] shift_res;
    logic                  lf;
    logic                  zf;
    logic                  of;

    // Operand and shift amount selection
    ex_operand_mux #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_operand_mux (
        .op_a        (op_a),
        .op_b        (op_b),
        .imm_ext     (imm_ext),
        .pc_4        (pc_4),
        .shamt       (shamt),
        .b_sel       (b_sel),
        .shamt_sel   (shamt_sel),
        .movz        (movz),
        .movn        (movn),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .shift_amt   (shift_amt),
        .link_target (link_target)
    );

    exec_alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_alu (
        .a   (alu_a),
        .b   (alu_b),
        .op  (alu_op),
        .res (alu_res),
        .lf  (lf),
        .zf  (zf),
        .of  (of)
    );

    // Shifts always act on rt, never the immediate
    barrel_shifter #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_shifter (
        .data_in  (op_b),
        .amount   (shift_amt),
        .op       (shift_op),
        .data_out (shift_res)
    );

    //////////////////////////////////////////////////////////////////////
    // EX/MEM
    //////////////////////////////////////////////////////////////////////

    // Raw rs feeds the pass-through path for moves
    ex_result_reg #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_result_reg (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue       (issue),
        .reg_w       (reg_w),
        .of_w_disen  (of_w_disen),
        .movz        (movz),
        .movn        (movn),
        .exres_sel   (exres_sel),
        .rd_addr     (rd_addr),
        .alu_res     (alu_res),
        .shift_res   (shift_res),
        .link_target (link_target),
        .pass_a      (op_a),
        .lf          (lf),
        .zf          (zf),
        .of          (of),
        .res_valid   (res_valid),
        .res_data    (res_data),
        .res_rd_addr (res_rd_addr),
        .res_reg_w   (res_reg_w),
        .res_lf      (res_lf),
        .res_zf      (res_zf),
        .res_of      (res_of)
    );

endmodule

/* logic/ex_result_reg.sv */
module ex_result_reg
    import ex_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  arst_n,
    // Instruction control
    input  logic                  issue,
    input  logic                  reg_w,
    input  logic                  of_w_disen,
    input  logic                  movz,
    input  logic                  movn,
    input  exres_sel_e            exres_sel,
    input  logic [REG_ADDR_W-1:0] rd_addr,
    // Result candidates
    input  logic [DATA_WIDTH-1:0] alu_res,
    input  logic [DATA_WIDTH-1:0] shift_res,
    input  logic [DATA_WIDTH-1:0] link_target,
    input  logic [DATA_WIDTH-1:0] pass_a,
    // ALU flags
    input  logic                  lf,
    input  logic                  zf,
    input  logic                  of,
    // EX/MEM outputs
    output logic                  res_valid,
    output logic [DATA_WIDTH-1:0] res_data,
    output logic [REG_ADDR_W-1:0] res_rd_addr,
    output logic                  res_reg_w,
    output logic                  res_lf,
    output logic                  res_zf,
    output logic                  res_of
);

    logic [DATA_WIDTH-1:0] ex_result;
    logic                  reg_w_qual;

    //////////////////////////////////////////////////////////////////////
    // Result select and write qualification
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (exres_sel)
            RES_ALU:    ex_result = alu_res;
            RES_SHIFT:  ex_result = shift_res;
            RES_LINK:   ex_result = link_target;
            RES_PASS_A: ex_result = pass_a;
            default:    ex_result = alu_res;
        endcase
    end

    // Kill the write on trapping overflow
    // movz writes only if rt is zero, movn only if not
    assign reg_w_qual = issue && reg_w
                        && !(of_w_disen && of)
                        && !(movz && !zf)
                        && !(movn && zf);

    //////////////////////////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////////////////////////

    // Valid and write enable live for one cycle per issue
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
            res_reg_w <= 1'b0;
        end else begin
            res_valid <= issue;
            res_reg_w <= reg_w_qual;
        end
    end

    // Payload holds between issues
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_data    <= '0;
            res_rd_addr <= '0;
            res_lf      <= 1'b0;
            res_zf      <= 1'b0;
            res_of      <= 1'b0;
        end else if (issue) begin
            res_data    <= ex_result;
            res_rd_addr <= rd_addr;
            res_lf      <= lf;
            res_zf      <= zf;
            res_of      <= of;
        end
    end

endmodule

/* logic/barrel_shifter.sv */
module barrel_shifter
    import ex_pkg::*;
#(
    parameter  int DATA_WIDTH = 32,
    localparam int SHAMT_W    = $clog2(DATA_WIDTH)
) (
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic [SHAMT_W-1:0]    amount,
    input  shift_op_e             op,
    output logic [DATA_WIDTH-1:0] data_out
);

    // One entry per stage plus the input
    logic [DATA_WIDTH-1:0] stage [SHAMT_W+1];
    logic                  shift_left;
    logic                  fill;

    // Mirror the word so one right shifter serves both directions
    function automatic logic [DATA_WIDTH-1:0] reverse(input logic [DATA_WIDTH-1:0] v);
        logic [DATA_WIDTH-1:0] r;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            r[i] = v[DATA_WIDTH-1-i];
        end
        return r;
    endfunction

    assign shift_left = (op == SH_SLL);

    // Sign fill for sra only
    assign fill = (op == SH_SRA) ? data_in[DATA_WIDTH-1] : 1'b0;

    assign stage[0] = shift_left ? reverse(data_in) : data_in;

    //////////////////////////////////////////////////////////////////////
    // Log stages
    //////////////////////////////////////////////////////////////////////

    // Stage i shifts by 2**i when its amount bit is set
    for (genvar i = 0; i < SHAMT_W; i++) begin : g_stage
        localparam int STEP = 1 << i;

        assign stage[i+1] = amount[i]
            ? {{STEP{fill}}, stage[i][DATA_WIDTH-1:STEP]}
            : stage[i];
    end

    // Undo the mirror for left shifts
    assign data_out = shift_left ? reverse(stage[SHAMT_W]) : stage[SHAMT_W];

endmodule

/* logic/exec_alu.sv */
module exec_alu
    import ex_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    input  alu_op_e               op,
    output logic [DATA_WIDTH-1:0] res,
    // Less than
    output logic                  lf,
    // Result is zero
    output logic                  zf,
    // Signed overflow
    output logic                  of
);

    localparam int HALF = DATA_WIDTH / 2;
    localparam int MSB  = DATA_WIDTH - 1;

    logic [DATA_WIDTH-1:0] sum;
    logic [DATA_WIDTH-1:0] diff;
    logic                  add_of;
    logic                  sub_of;
    logic                  lt_signed;
    logic                  lt_unsigned;

    //////////////////////////////////////////////////////////////////////
    // Adder, subtractor and compare
    //////////////////////////////////////////////////////////////////////

    assign sum  = a + b;
    assign diff = a - b;

    // Same operand signs but sum sign flipped
    assign add_of = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
    // Operand signs differ and result takes the sign of b
    assign sub_of = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    //////////////////////////////////////////////////////////////////////
    // Result
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            ALU_ADD,
            ALU_ADDU: res = sum;
            ALU_SUB,
            ALU_SUBU: res = diff;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_NOR:  res = ~(a | b);
            ALU_SLT:  res = {{(DATA_WIDTH-1){1'b0}}, lt_signed};
            ALU_SLTU: res = {{(DATA_WIDTH-1){1'b0}}, lt_unsigned};
            // Low half of b moves up, zero below
            ALU_LUI:  res = {b[HALF-1:0], {HALF{1'b0}}};
            default:  res = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Flags
    //////////////////////////////////////////////////////////////////////

    // Unsigned compare only for sltu
    assign lf = (op == ALU_SLTU) ? lt_unsigned : lt_signed;

    assign zf = (res == '0);

    // Trapping ops only
    always_comb begin
        case (op)
            ALU_ADD: of = add_of;
            ALU_SUB: of = sub_of;
            default: of = 1'b0;
        endcase
    end

endmodule

/* logic/ex_operand_mux.sv */
module ex_operand_mux #(
    parameter  int DATA_WIDTH = 32,
    localparam int SHAMT_W    = $clog2(DATA_WIDTH)
) (
    // Register operands and immediate
    input  logic [DATA_WIDTH-1:0] op_a,
    input  logic [DATA_WIDTH-1:0] op_b,
    input  logic [DATA_WIDTH-1:0] imm_ext,
    input  logic [DATA_WIDTH-1:0] pc_4,
    // Shift amount from the instruction field
    input  logic [SHAMT_W-1:0]    shamt,
    // Selects
    input  logic                  b_sel,
    input  logic                  shamt_sel,
    input  logic                  movz,
    input  logic                  movn,
    // To ALU and shifter
    output logic [DATA_WIDTH-1:0] alu_a,
    output logic [DATA_WIDTH-1:0] alu_b,
    output logic [SHAMT_W-1:0]    shift_amt,
    // To result select
    output logic [DATA_WIDTH-1:0] link_target
);

    //////////////////////////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////////////////////////

    // Moves run as 0 | rt through the ALU
    assign alu_a = (movz || movn) ? '0 : op_a;

    // Immediate for I-type, branches and lui
    assign alu_b = b_sel ? imm_ext : op_b;

    // Variable shifts take the amount from rs
    assign shift_amt = shamt_sel ? op_a[SHAMT_W-1:0] : shamt;

    //////////////////////////////////////////////////////////////////////
    // Branch / link target
    //////////////////////////////////////////////////////////////////////

    // Word offset relative to the delay slot
    assign link_target = pc_4 + (imm_ext << 2);

endmodule

/* logic/ex_pkg.sv */
package ex_pkg;

    //////////////////////////////////////////////////////////////////////
    // Register file addressing
    //////////////////////////////////////////////////////////////////////

    // 32 general purpose registers
    localparam int REG_ADDR_W = 5;

    //////////////////////////////////////////////////////////////////////
    // ALU operations
    //////////////////////////////////////////////////////////////////////

    // Encoding as produced by the decoder
    typedef enum logic [3:0] {
        // Signed add, may trap on overflow
        ALU_ADD  = 4'd0,
        ALU_ADDU = 4'd1,
        // Signed subtract, may trap on overflow
        ALU_SUB  = 4'd2,
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        // Set on less than
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        // Immediate into upper half
        ALU_LUI  = 4'd10
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // Shifter operations
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        SH_SLL = 2'd0,
        SH_SRL = 2'd1,
        // Sign fill
        SH_SRA = 2'd2
    } shift_op_e;

    //////////////////////////////////////////////////////////////////////
    // Execute result source
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        RES_ALU    = 2'd0,
        RES_SHIFT  = 2'd1,
        // Branch and link target
        RES_LINK   = 2'd2,
        // Raw operand A, used by the moves
        RES_PASS_A = 2'd3
    } exres_sel_e;

endpackage
